//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := tb_lvda
FILELIST   := src.f
OBJ_DIR    := obj_dir
PASS_MSG   := STATUS: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/command_decode.sv
module command_decode (
    input  logic                sim_clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  lvda_pkg::lvda_cmd_t cmd,
    output lvda_pkg::exec_cmd_t dec
);
    import lvda_pkg::*;

    logic op_ok;
    logic group_ok;
    logic cmd_err;

    // ***********************************************************
    // Command checks
    // ***********************************************************
    always_comb begin
        op_ok = cmd.op inside {OP_READ_DISC, OP_READ_INTR, OP_SET_MASK, OP_LOAD_BUF};

        // Group only matters for discrete reads.
        if (cmd.op == OP_READ_DISC) begin
            group_ok = (int'(cmd.group) < NUM_GROUPS);
        end else begin
            group_ok = 1'b1;
        end

        cmd_err = !op_ok || !group_ok;
    end

    // ***********************************************************
    // Decode register
    // ***********************************************************
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= cmd_valid;
            if (cmd_valid) begin
                dec.cmd <= cmd;
                dec.err <= cmd_err;
            end
        end
    end

    // Execution relies on this to treat its case default as unreachable.
    a_dec_op_legal: assert property (
        @(posedge sim_clk) disable iff (rst)
        (dec.valid && !dec.err)
            |-> (dec.cmd.op inside {OP_READ_DISC, OP_READ_INTR, OP_SET_MASK, OP_LOAD_BUF})
    ) else $error("decoded command passed with an illegal opcode");

endmodule

//--- rtl/command_exec.sv
module command_exec (
    input  logic                        sim_clk,
    input  logic                        rst,
    input  lvda_pkg::exec_cmd_t         dec,
    input  logic [lvda_pkg::DISC_W-1:0] disc,
    input  logic [lvda_pkg::INTR_W-1:0] intr_level,
    output logic                        result_valid,
    output lvda_pkg::lvda_rsp_t         result,
    output logic                        buf_we,
    output logic                        intc
);
    import lvda_pkg::*;

    logic               do_cmd;
    logic               clear_en;
    logic               mask_we;
    logic [INTR_W-1:0]  clear_bits;
    logic [INTR_W-1:0]  mask_data;
    logic [INTR_W-1:0]  pending_masked;
    logic [GROUP_W-1:0] group_bits;
    lvda_rsp_t          rsp_next;

    assign do_cmd     = dec.valid && !dec.err;
    assign clear_en   = do_cmd && (dec.cmd.op == OP_READ_INTR);
    assign clear_bits = pending_masked;    // Exactly what is reported.
    assign mask_we    = do_cmd && (dec.cmd.op == OP_SET_MASK);
    assign mask_data  = dec.cmd.data[INTR_W-1:0];

    interrupt_register interrupt_register0 (
        .sim_clk        (sim_clk),
        .rst            (rst),
        .intr_level     (intr_level),
        .clear_en       (clear_en),
        .clear_bits     (clear_bits),
        .mask_we        (mask_we),
        .mask_data      (mask_data),
        .pending_masked (pending_masked),
        .intc           (intc)
    );

    // ***********************************************************
    // Response data
    // ***********************************************************
    always_comb begin
        case (dec.cmd.group)
            2'd0:    group_bits = disc[0*GROUP_W +: GROUP_W];
            2'd1:    group_bits = disc[1*GROUP_W +: GROUP_W];
            2'd2:    group_bits = disc[2*GROUP_W +: GROUP_W];
            default: group_bits = '0;
        endcase

        rsp_next.status = ST_OK;
        rsp_next.data   = '0;
        if (dec.err) begin
            rsp_next.status = ST_ERR;   // Data stays zero.
        end else begin
            case (dec.cmd.op)
                OP_READ_DISC: rsp_next.data = DATA_W'(group_bits);
                OP_READ_INTR: rsp_next.data = DATA_W'(pending_masked);
                OP_SET_MASK:  rsp_next.data = DATA_W'(mask_data);
                OP_LOAD_BUF:  rsp_next.data = dec.cmd.data;
                default:      rsp_next.status = ST_ERR;
            endcase
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            buf_we       <= 1'b0;
        end else begin
            result_valid <= dec.valid;
            buf_we       <= do_cmd && (dec.cmd.op == OP_LOAD_BUF);
            if (dec.valid) begin
                result <= rsp_next;
            end
        end
    end

endmodule

//--- rtl/discrete_filter.sv
module discrete_filter #(
    parameter int WIDTH = 8
) (
    input  logic             sim_clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] filtered
);
    import lvda_pkg::*;

    logic [WIDTH-1:0] sync_q1;
    logic [WIDTH-1:0] sync_q2;

    // ***********************************************************
    // Input synchronizer
    // ***********************************************************
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw;      // Levels arrive asynchronously.
            sync_q2 <= sync_q1;
        end
    end

    // ***********************************************************
    // Per-bit transient filter
    // ***********************************************************
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        logic [FILTER_CNT_W-1:0] cnt;
        logic                    flt;

        // A bit follows its input only after a full run of
        // disagreeing samples; any agreeing sample restarts the run.
        always_ff @(posedge sim_clk) begin
            if (rst) begin
                cnt <= '0;
                flt <= 1'b0;
            end else if (sync_q2[i] == flt) begin
                cnt <= '0;
            end else if (cnt == FILTER_CNT_W'(FILTER_LEN - 1)) begin
                cnt <= '0;
                flt <= sync_q2[i];   // Change accepted.
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        assign filtered[i] = flt;
    end

endmodule

//--- rtl/interrupt_register.sv
module interrupt_register (
    input  logic                        sim_clk,
    input  logic                        rst,
    input  logic [lvda_pkg::INTR_W-1:0] intr_level,
    input  logic                        clear_en,
    input  logic [lvda_pkg::INTR_W-1:0] clear_bits,
    input  logic                        mask_we,
    input  logic [lvda_pkg::INTR_W-1:0] mask_data,
    output logic [lvda_pkg::INTR_W-1:0] pending_masked,
    output logic                        intc
);
    import lvda_pkg::*;

    logic [INTR_W-1:0] level_q;
    logic [INTR_W-1:0] rise;
    logic [INTR_W-1:0] pending;
    logic [INTR_W-1:0] mask;
    logic [INTR_W-1:0] clr;

    assign rise = intr_level & ~level_q;
    assign clr  = clear_en ? clear_bits : '0;

    // ***********************************************************
    // Pending and mask registers
    // ***********************************************************
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            level_q <= '0;
            pending <= '0;
            mask    <= MASK_RESET;
        end else begin
            level_q <= intr_level;
            // New edges latch regardless of mask, and beat a clear.
            pending <= (pending & ~clr) | rise;
            if (mask_we) begin
                mask <= mask_data;
            end
        end
    end

    assign pending_masked = pending & mask;
    assign intc           = |pending_masked;

    a_intc_level: assert property (
        @(posedge sim_clk) disable iff (rst)
        intc == (pending_masked != '0)
    ) else $error("intc disagrees with the masked pending bits");

endmodule

//--- rtl/lvda_pkg.sv
package lvda_pkg;

    // ***********************************************************
    // Widths and counts
    // ***********************************************************
    localparam int DATA_W     = 26;  // Data field and buffer bus.
    localparam int DISC_W     = 24;
    localparam int GROUP_W    = 8;
    localparam int NUM_GROUPS = 3;   // Valid discrete groups.
    localparam int GSEL_W     = 2;
    localparam int OP_W       = 3;
    localparam int INTR_W     = 7;

    // Transient filter.
    localparam int FILTER_LEN   = 3;
    localparam int FILTER_CNT_W = $clog2(FILTER_LEN + 1);

    // Everything enabled out of reset.
    localparam logic [INTR_W-1:0] MASK_RESET = '1;

    // ***********************************************************
    // Encodings
    // ***********************************************************
    // Codes 4 to 7 are rejected by the decoder.
    typedef enum logic [OP_W-1:0] {
        OP_READ_DISC = 3'd0,
        OP_READ_INTR = 3'd1,
        OP_SET_MASK  = 3'd2,
        OP_LOAD_BUF  = 3'd3
    } opcode_e;

    typedef enum logic {
        ST_OK  = 1'b0,
        ST_ERR = 1'b1
    } status_e;

    // Command word from the guidance computer.
    typedef struct packed {
        opcode_e             op;
        logic [GSEL_W-1:0]   group;
        logic [DATA_W-1:0]   data;
    } lvda_cmd_t;

    typedef struct packed {
        status_e             status;
        logic [DATA_W-1:0]   data;
    } lvda_rsp_t;

    // Decoder to execution stage.
    typedef struct packed {
        logic                valid;
        lvda_cmd_t           cmd;
        logic                err;    // Bad opcode or group.
    } exec_cmd_t;

endpackage

//--- rtl/lvda_top.sv
module lvda_top (
    input  logic                        sim_clk,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  lvda_pkg::lvda_cmd_t         cmd,
    input  logic [lvda_pkg::DISC_W-1:0] din,
    input  logic [lvda_pkg::INTR_W-1:0] intr,
    output logic                        rsp_valid,
    output lvda_pkg::lvda_rsp_t         rsp,
    output logic [lvda_pkg::DATA_W-1:0] brd,
    output logic                        intc
);
    import lvda_pkg::*;

    logic [DISC_W-1:0] disc;
    logic [INTR_W-1:0] intr_level;
    exec_cmd_t         dec;
    logic              result_valid;
    lvda_rsp_t         result;
    logic              buf_we;

    // ***********************************************************
    // Input side
    // ***********************************************************
    discrete_filter #(.WIDTH(DISC_W)) disc_filter0 (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .raw      (din),
        .filtered (disc)
    );

    discrete_filter #(.WIDTH(INTR_W)) intr_filter0 (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .raw      (intr),
        .filtered (intr_level)
    );

    command_decode command_decode0 (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .dec       (dec)
    );

    // Execution and interrupt register.
    command_exec command_exec0 (
        .sim_clk      (sim_clk),
        .rst          (rst),
        .dec          (dec),
        .disc         (disc),
        .intr_level   (intr_level),
        .result_valid (result_valid),
        .result       (result),
        .buf_we       (buf_we),
        .intc         (intc)
    );

    // ***********************************************************
    // Output side
    // ***********************************************************
    output_buffer output_buffer0 (
        .sim_clk      (sim_clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result       (result),
        .buf_we       (buf_we),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .brd          (brd)
    );

endmodule

//--- rtl/output_buffer.sv
module output_buffer (
    input  logic                        sim_clk,
    input  logic                        rst,
    input  logic                        result_valid,
    input  lvda_pkg::lvda_rsp_t         result,
    input  logic                        buf_we,
    output logic                        rsp_valid,
    output lvda_pkg::lvda_rsp_t         rsp,
    output logic [lvda_pkg::DATA_W-1:0] brd
);
    import lvda_pkg::*;

    logic load_buf;

    assign load_buf = result_valid && buf_we;

    // ***********************************************************
    // Response register
    // ***********************************************************
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= result_valid;
            if (result_valid) begin
                rsp <= result;
            end
        end
    end

    // ***********************************************************
    // Output buffer register
    // ***********************************************************
    // Loads on the same edge that issues the response.
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            brd <= '0;
        end else if (load_buf) begin
            brd <= result.data;
        end
    end

    a_err_zero_data: assert property (
        @(posedge sim_clk) disable iff (rst)
        (rsp_valid && rsp.status == ST_ERR) |-> (rsp.data == '0)
    ) else $error("error response carries nonzero data");

endmodule

//--- src.f
rtl/lvda_pkg.sv
rtl/discrete_filter.sv
rtl/interrupt_register.sv
rtl/command_decode.sv
rtl/command_exec.sv
rtl/output_buffer.sv
rtl/lvda_top.sv
test/tb_lvda.sv

//--- test/tb_lvda.sv
module tb_lvda;
    import lvda_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DLY     = 2;
    localparam int HOLD_CYCLES   = 10;   // Longer than the filter delay.
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 5000;

    typedef struct packed {
        lvda_rsp_t         rsp;
        logic [DATA_W-1:0] brd;
        logic [31:0]       edge_no;   // Edge that samples the command.
    } exp_entry_t;

    logic              sim_clk;
    logic              rst;
    logic              cmd_valid;
    lvda_cmd_t         cmd;
    logic [DISC_W-1:0] din;
    logic [INTR_W-1:0] intr;
    logic              rsp_valid;
    lvda_rsp_t         rsp;
    logic [DATA_W-1:0] brd;
    logic              intc;

    integer            seed;
    logic [31:0]       cycle;
    exp_entry_t        exp_q[$];

    // Reference model state.
    logic [INTR_W-1:0] m_mask;
    logic [INTR_W-1:0] m_pending;
    logic [DISC_W-1:0] m_disc;
    logic [DATA_W-1:0] m_buf;

    lvda_top dut0 (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .din       (din),
        .intr      (intr),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .brd       (brd),
        .intc      (intc)
    );

    always #(CLK_PERIOD / 2) sim_clk = ~sim_clk;

    always @(posedge sim_clk) cycle <= cycle + 1;

    // ***********************************************************
    // Failure reporting
    // ***********************************************************
    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s at time %0t", what, $time);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // ***********************************************************
    // Reference model
    // ***********************************************************
    function automatic lvda_rsp_t ref_response(input lvda_cmd_t c);
        lvda_rsp_t         r;
        logic [INTR_W-1:0] reported;
        r.status = ST_OK;
        r.data   = '0;
        reported = m_pending & m_mask;
        case (int'(c.op))
            0: begin
                if (int'(c.group) < NUM_GROUPS)
                    r.data = DATA_W'(m_disc[int'(c.group) * GROUP_W +: GROUP_W]);
                else
                    r.status = ST_ERR;
            end
            1: begin
                r.data    = DATA_W'(reported);
                m_pending = m_pending & ~reported;   // Read clears what it reports.
            end
            2: begin
                m_mask = c.data[INTR_W-1:0];
                r.data = DATA_W'(m_mask);
            end
            3: begin
                m_buf  = c.data;
                r.data = c.data;
            end
            default: r.status = ST_ERR;
        endcase
        return r;
    endfunction

    // ***********************************************************
    // Stimulus tasks
    // ***********************************************************
    task automatic send_cmd(input logic [2:0] op, input logic [1:0] group,
                            input logic [DATA_W-1:0] data);
        lvda_cmd_t  c;
        exp_entry_t e;
        c.op    = opcode_e'(op);
        c.group = group;
        c.data  = data;
        @(posedge sim_clk);
        #DRIVE_DLY;
        cmd_valid = 1'b1;
        cmd       = c;
        e.rsp     = ref_response(c);
        e.brd     = m_buf;
        e.edge_no = cycle + 1;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        @(posedge sim_clk);
        #DRIVE_DLY;
        cmd_valid = 1'b0;
        cmd       = '0;
        for (int k = 0; k < DRAIN_TIMEOUT && exp_q.size() != 0; k++) begin
            @(negedge sim_clk);
        end
        if (exp_q.size() != 0)
            report_problem("responses still outstanding after the drain timeout");
    endtask

    // Levels change, then hold long enough to pass the filters.
    task automatic set_lines(input logic [DISC_W-1:0] d, input logic [INTR_W-1:0] i);
        @(posedge sim_clk);
        #DRIVE_DLY;
        m_pending = m_pending | (i & ~intr);
        m_disc    = d;
        din       = d;
        intr      = i;
        repeat (HOLD_CYCLES) @(posedge sim_clk);
    endtask

    task automatic wait_intc(input logic level);
        int k;
        for (k = 0; k < DRAIN_TIMEOUT && intc !== level; k++) begin
            @(negedge sim_clk);
        end
        if (intc !== level)
            report_problem("intc did not reach the expected level in time");
    endtask

    // ***********************************************************
    // Compare process
    // ***********************************************************
    // At a falling edge the response is taken on the next rising edge, cycle + 1.
    always @(negedge sim_clk) begin : compare
        exp_entry_t e;
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                report_problem("a response came with no command outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value("rsp_latency", cycle + 1 - e.edge_no, 32'd3);
                check_value("rsp.status", 32'(rsp.status), 32'(e.rsp.status));
                check_value("rsp.data", 32'(rsp.data), 32'(e.rsp.data));
                check_value("brd", 32'(brd), 32'(e.brd));
            end
        end else if (!rst && exp_q.size() != 0 && cycle > exp_q[0].edge_no + 2) begin
            report_problem("a command got no response within 3 cycles");
        end
    end

    initial begin : watchdog
        repeat (RUN_TIMEOUT) @(posedge sim_clk);
        report_problem("simulation ran past its cycle limit");
    end

    // ***********************************************************
    // Main sequence
    // ***********************************************************
    initial begin
        seed      = 35;
        sim_clk   = 1'b0;
        rst       = 1'b1;
        cycle     = '0;
        cmd_valid = 1'b0;
        cmd       = '0;
        din       = '0;
        intr      = '0;
        m_mask    = MASK_RESET;
        m_pending = '0;
        m_disc    = '0;
        m_buf     = '0;

        repeat (2) @(posedge sim_clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge sim_clk);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("intc", 32'(intc), 32'd0);
        check_value("brd", 32'(brd), 32'd0);
        send_cmd(3'd1, 2'd0, '0);
        drain();

        // Discrete groups, group 3 is out of range.
        set_lines(DISC_W'($random(seed)), '0);
        for (int g = 0; g < 4; g++) send_cmd(3'd0, g[1:0], '0);
        drain();

        send_cmd(3'd3, 2'd0, DATA_W'($random(seed)));
        send_cmd(3'd0, 2'd1, '0);
        send_cmd(3'd0, 2'd2, '0);   // brd must hold here.
        drain();

        // Interrupts with everything unmasked.
        set_lines(m_disc, 7'b0000101);
        wait_intc(1'b1);
        send_cmd(3'd1, 2'd0, '0);
        send_cmd(3'd1, 2'd0, '0);
        drain();
        wait_intc(1'b0);

        // Masked lines latch silently.
        set_lines(m_disc, '0);
        send_cmd(3'd2, 2'd0, DATA_W'(7'b0001111));
        drain();
        set_lines(m_disc, 7'b1110011);
        wait_intc(1'b1);
        send_cmd(3'd1, 2'd0, '0);
        drain();
        wait_intc(1'b0);
        send_cmd(3'd2, 2'd0, DATA_W'(7'b1111111));
        drain();
        wait_intc(1'b1);
        send_cmd(3'd1, 2'd0, '0);
        send_cmd(3'd1, 2'd0, '0);
        drain();
        wait_intc(1'b0);

        // Bad opcodes leave mask and buffer alone.
        for (int op = 4; op < 8; op++) send_cmd(op[2:0], 2'd0, DATA_W'($random(seed)));
        drain();
        set_lines(m_disc, '0);
        set_lines(m_disc, 7'b1111111);
        send_cmd(3'd1, 2'd0, '0);
        drain();

        set_lines(DISC_W'($random(seed)), 7'b1010101);
        for (int n = 0; n < 32; n++) begin
            send_cmd(3'($random(seed)), 2'($random(seed)), DATA_W'($random(seed)));
        end
        drain();
        wait_intc(|(m_pending & m_mask));

        $display("STATUS: PASS");
        $finish;
    end

endmodule
